/* verilog/tracker_pkg.sv */
`default_nettype none

package tracker_pkg;

  ////////////////////////////////////////
  // widths with a meaning

  // sum and divider width
  localparam int SUM_WIDTH = 32;

  typedef logic [10:0] hcount_t;
  typedef logic [9:0]  vcount_t;
  typedef logic [15:0] rgb565_t;
  typedef logic [11:0] rgb444_t;
  typedef logic [7:0]  chroma_t;
  typedef logic [3:0]  nibble_t;

  // one raster position, as it leaves the timing source
  typedef struct packed {
    rgb565_t pixel;
    hcount_t hcount;
    vcount_t vcount;
    logic    blank;
    logic    hsync;
    logic    vsync;
  } video_beat_t;

  // what the output shows
  typedef enum logic [1:0] {
    VIEW_CAMERA    = 2'd0,
    VIEW_MASK      = 2'd1,
    VIEW_CROSSHAIR = 2'd2
  } view_mode_e;

  typedef struct packed {
    nibble_t    lower_bound;
    nibble_t    upper_bound;
    view_mode_e view;
  } track_cfg_t;

  // blanked beat, loaded into the beat chains on reset
  localparam video_beat_t BEAT_IDLE = '{pixel: '0, hcount: '0, vcount: '0,
                                        blank: 1'b1, hsync: 1'b0, vsync: 1'b0};

endpackage

`default_nettype wire

/* verilog/seq_divider.sv */
`default_nettype none

module seq_divider import tracker_pkg::*; (
  input  logic                 clk_65mhz,
  input  logic                 sys_rst,
  input  logic                 start,
  input  logic [SUM_WIDTH-1:0] dividend,
  input  logic [SUM_WIDTH-1:0] divisor,
  output logic [SUM_WIDTH-1:0] quotient,
  output logic                 busy,
  output logic                 done
);

  localparam int CNT_W = $clog2(SUM_WIDTH);

  typedef enum logic {IDLE, RUN} div_state_e;

  div_state_e           state;
  logic [CNT_W-1:0]     bit_cnt;
  logic [SUM_WIDTH-1:0] rem_r, quo_r, den_r;

  // one restoring step, returns {remainder, quotient}
  function automatic logic [2*SUM_WIDTH-1:0] div_step(
    input logic [SUM_WIDTH-1:0] rem,
    input logic [SUM_WIDTH-1:0] quo,
    input logic [SUM_WIDTH-1:0] den
  );
    logic [SUM_WIDTH:0] shifted;
    logic [SUM_WIDTH:0] trial;
    shifted = {rem, quo[SUM_WIDTH-1]};
    trial   = shifted - {1'b0, den};
    // borrow means the divisor did not fit
    if (trial[SUM_WIDTH]) begin
      return {shifted[SUM_WIDTH-1:0], quo[SUM_WIDTH-2:0], 1'b0};
    end
    return {trial[SUM_WIDTH-1:0], quo[SUM_WIDTH-2:0], 1'b1};
  endfunction

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      state   <= IDLE;
      bit_cnt <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          // first bit is taken on the start edge
          if (start) begin
            {rem_r, quo_r} <= div_step('0, dividend, divisor);
            den_r   <= divisor;
            bit_cnt <= CNT_W'(1);
            state   <= RUN;
          end
        end
        RUN: begin
          {rem_r, quo_r} <= div_step(rem_r, quo_r, den_r);
          bit_cnt <= bit_cnt + CNT_W'(1);
          // last quotient bit
          if (bit_cnt == CNT_W'(SUM_WIDTH - 1)) begin
            state <= IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign busy     = (state == RUN);
  assign quotient = quo_r;

endmodule

`default_nettype wire

/* verilog/chroma_convert.sv */
`default_nettype none

module chroma_convert import tracker_pkg::*; (
  input  logic        clk_65mhz,
  input  logic        sys_rst,
  input  video_beat_t beat_in,
  output video_beat_t beat_out,
  output chroma_t     cr
);

  // channels widened to 8 bits
  logic [7:0] r8, g8, b8;
  // stage 1: weighted products
  logic [15:0] prod_r, prod_g, prod_b;
  // stage 2: signed sum
  logic signed [17:0] cr_sum;
  // stage 3 input, before the clamp
  logic signed [17:0] cr_full;
  video_beat_t beat_d [3];

  assign r8 = {beat_in.pixel[15:11], 3'b000};
  assign g8 = {beat_in.pixel[10:5], 2'b00};
  assign b8 = {beat_in.pixel[4:0], 3'b000};

  // offset after the arithmetic shift
  assign cr_full = (cr_sum >>> 8) + 18'sd128;

  always_ff @(posedge clk_65mhz) begin
    prod_r <= r8 * 8'd112;
    prod_g <= g8 * 8'd94;
    prod_b <= b8 * 8'd18;
    cr_sum <= $signed({2'b00, prod_r}) - $signed({2'b00, prod_g})
              - $signed({2'b00, prod_b});
    // clamp to 0..255
    if (cr_full < 0) begin
      cr <= 8'd0;
    end else if (cr_full > 18'sd255) begin
      cr <= 8'd255;
    end else begin
      cr <= cr_full[7:0];
    end
  end

  // beat rides beside the three arithmetic stages
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      beat_d <= '{default: BEAT_IDLE};
    end else begin
      beat_d[0] <= beat_in;
      beat_d[1] <= beat_d[0];
      beat_d[2] <= beat_d[1];
    end
  end

  assign beat_out = beat_d[2];

endmodule

`default_nettype wire

/* verilog/chroma_mask.sv */
`default_nettype none

module chroma_mask import tracker_pkg::*; (
  input  logic        clk_65mhz,
  input  logic        sys_rst,
  input  video_beat_t beat_in,
  input  chroma_t     cr,
  input  track_cfg_t  cfg,
  output video_beat_t beat_out,
  output logic        in_mask
);

  nibble_t cr_top;
  logic    in_band;

  // only the top nibble of cr is compared
  assign cr_top  = cr[7:4];
  assign in_band = (cr_top >= cfg.lower_bound) && (cr_top <= cfg.upper_bound);

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      beat_out <= BEAT_IDLE;
      in_mask  <= 1'b0;
    end else begin
      beat_out <= beat_in;
      // blanked beats never count
      in_mask  <= !beat_in.blank && in_band;
    end
  end

endmodule

`default_nettype wire

/* verilog/centroid_accum.sv */
`default_nettype none

module centroid_accum import tracker_pkg::*; #(
  parameter int H_ACTIVE = 1024,
  parameter int V_ACTIVE = 768
) (
  input  logic        clk_65mhz,
  input  logic        sys_rst,
  input  video_beat_t beat_in,
  input  logic        in_mask,
  output hcount_t     com_x,
  output vcount_t     com_y,
  output logic        com_valid
);

  logic [SUM_WIDTH-1:0] x_sum, y_sum, pix_count;
  logic [SUM_WIDTH-1:0] x_quot, y_quot;
  logic frame_close, div_start;
  logic x_busy, y_busy, x_done, y_done;
  // centroid inside the active area, checked by the bound properties
  logic com_in_area;

  ////////////////////////////////////////
  // frame sums

  // beat at 0,0 closes the old frame and opens the new one
  assign frame_close = (beat_in.hcount == '0) && (beat_in.vcount == '0);
  // empty frame starts nothing
  assign div_start   = frame_close && (pix_count != '0);

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      x_sum     <= '0;
      y_sum     <= '0;
      pix_count <= '0;
    end else if (frame_close) begin
      // closing beat counts toward the new frame
      x_sum     <= in_mask ? SUM_WIDTH'(beat_in.hcount) : '0;
      y_sum     <= in_mask ? SUM_WIDTH'(beat_in.vcount) : '0;
      pix_count <= in_mask ? SUM_WIDTH'(1) : '0;
    end else if (in_mask) begin
      x_sum     <= x_sum + SUM_WIDTH'(beat_in.hcount);
      y_sum     <= y_sum + SUM_WIDTH'(beat_in.vcount);
      pix_count <= pix_count + SUM_WIDTH'(1);
    end
  end

  ////////////////////////////////////////
  // mean column and row

  // dividers latch the totals on start
  seq_divider u_div_x (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .start     (div_start),
    .dividend  (x_sum),
    .divisor   (pix_count),
    .quotient  (x_quot),
    .busy      (x_busy),
    .done      (x_done)
  );

  seq_divider u_div_y (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .start     (div_start),
    .dividend  (y_sum),
    .divisor   (pix_count),
    .quotient  (y_quot),
    .busy      (y_busy),
    .done      (y_done)
  );

  // both finish together, held until the next frame
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      com_x     <= '0;
      com_y     <= '0;
      com_valid <= 1'b0;
    end else begin
      com_valid <= x_done && y_done;
      if (x_done && y_done) begin
        com_x <= hcount_t'(x_quot);
        com_y <= vcount_t'(y_quot);
      end
    end
  end

  assign com_in_area = (com_x < H_ACTIVE) && (com_y < V_ACTIVE);

endmodule

`default_nettype wire

/* verilog/crosshair_overlay.sv */
`default_nettype none

module crosshair_overlay import tracker_pkg::*; #(
  parameter int H_ACTIVE = 1024,
  parameter int V_ACTIVE = 768
) (
  input  logic        clk_65mhz,
  input  logic        sys_rst,
  input  video_beat_t beat_in,
  input  logic        in_mask,
  input  track_cfg_t  cfg,
  input  hcount_t     com_x,
  input  vcount_t     com_y,
  output rgb444_t     out_pixel,
  output logic        out_hsync,
  output logic        out_vsync
);

  localparam rgb444_t LINE_GREEN = 12'h0F0;
  localparam rgb444_t MASK_WHITE = 12'hFFF;

  rgb444_t camera_px;
  rgb444_t view_px;
  logic    in_area;
  logic    on_line;

  // top nibble of each channel
  assign camera_px = {beat_in.pixel[15:12], beat_in.pixel[10:7], beat_in.pixel[4:1]};

  // crosshair stays inside the active area
  assign in_area = (beat_in.hcount < H_ACTIVE) && (beat_in.vcount < V_ACTIVE);
  assign on_line = in_area && ((beat_in.hcount == com_x) || (beat_in.vcount == com_y));

  ////////////////////////////////////////
  // view select

  always_comb begin
    case (cfg.view)
      VIEW_MASK:      view_px = in_mask ? MASK_WHITE : '0;
      VIEW_CROSSHAIR: view_px = on_line ? LINE_GREEN : camera_px;
      default:        view_px = camera_px;
    endcase
  end

  // blanking and syncs, one register
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      out_pixel <= '0;
      out_hsync <= 1'b0;
      out_vsync <= 1'b0;
    end else begin
      out_pixel <= beat_in.blank ? '0 : view_px;
      out_hsync <= beat_in.hsync;
      out_vsync <= beat_in.vsync;
    end
  end

endmodule

`default_nettype wire

/* verilog/color_tracker_top.sv */
`default_nettype none

module color_tracker_top import tracker_pkg::*; #(
  parameter int H_ACTIVE = 1024,
  parameter int V_ACTIVE = 768
) (
  input  logic        clk_65mhz,
  input  logic        sys_rst,
  input  video_beat_t beat_in,
  input  track_cfg_t  cfg,
  output rgb444_t     out_pixel,
  output logic        out_hsync,
  output logic        out_vsync,
  output hcount_t     com_x,
  output vcount_t     com_y,
  output logic        com_valid
);

  // convert to mask
  video_beat_t conv_beat;
  chroma_t     conv_cr;
  // mask to accum and overlay
  video_beat_t mask_beat;
  logic        mask_bit;

  ////////////////////////////////////////
  // pixel path, 3 + 1 + 1 cycles

  chroma_convert u_convert (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .beat_in   (beat_in),
    .beat_out  (conv_beat),
    .cr        (conv_cr)
  );

  chroma_mask u_mask (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .beat_in   (conv_beat),
    .cr        (conv_cr),
    .cfg       (cfg),
    .beat_out  (mask_beat),
    .in_mask   (mask_bit)
  );

  // centroid side branch
  centroid_accum #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE)
  ) u_accum (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .beat_in   (mask_beat),
    .in_mask   (mask_bit),
    .com_x     (com_x),
    .com_y     (com_y),
    .com_valid (com_valid)
  );

  crosshair_overlay #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE)
  ) u_overlay (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .beat_in   (mask_beat),
    .in_mask   (mask_bit),
    .cfg       (cfg),
    .com_x     (com_x),
    .com_y     (com_y),
    .out_pixel (out_pixel),
    .out_hsync (out_hsync),
    .out_vsync (out_vsync)
  );

endmodule

`default_nettype wire

/* tests/tracker_props.sv */
`default_nettype none

module tracker_props (
  input logic clk_65mhz,
  input logic sys_rst,
  input logic com_valid,
  input logic com_in_area,
  input logic div_start,
  input logic x_busy,
  input logic y_busy
);

  // failed assertions so far
  int fail_count = 0;

  // centroid update lasts one cycle
  valid_pulse: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    com_valid |=> !com_valid)
  else begin
    $error("com_valid stayed high for more than one cycle");
    fail_count++;
  end

  // centroid inside the active area
  com_bounds: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    com_in_area)
  else begin
    $error("centroid lies outside the active area");
    fail_count++;
  end

  // no restart of a running divide
  start_idle: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    div_start |-> !x_busy && !y_busy)
  else begin
    $error("divider start while a divider is busy");
    fail_count++;
  end

endmodule

bind centroid_accum tracker_props u_props (
  .clk_65mhz   (clk_65mhz),
  .sys_rst     (sys_rst),
  .com_valid   (com_valid),
  .com_in_area (com_in_area),
  .div_start   (div_start),
  .x_busy      (x_busy),
  .y_busy      (y_busy)
);

`default_nettype wire

/* tests/tracker_checker.sv */
`default_nettype none

module tracker_checker import tracker_pkg::*; #(
  parameter int H_ACTIVE = 32,
  parameter int V_ACTIVE = 24
) (
  input logic        clk_65mhz,
  input logic        sys_rst,
  input video_beat_t beat_in,
  input track_cfg_t  cfg,
  input rgb444_t     out_pixel,
  input logic        out_hsync,
  input logic        out_vsync,
  input hcount_t     com_x,
  input vcount_t     com_y,
  input logic        com_valid
);

  string test_name = "reset";
  int    test_checks = 0;
  int    test_errors = 0;
  int    test_pulses = 0;
  int    total_checks = 0;
  int    total_errors = 0;
  // negedge count for the history rings
  int    cyc = 0;

  video_beat_t beat_h [8];
  logic        mask_h [8];
  track_cfg_t  cfg_prev;
  // model frame sums and centroid
  longint      sum_x, sum_y, count;
  hcount_t     model_x, exp_x;
  vcount_t     model_y, exp_y;
  logic        armed;
  int          due;

  initial begin
    beat_h   = '{default: BEAT_IDLE};
    mask_h   = '{default: 1'b0};
    cfg_prev = '0;
    sum_x    = 0;
    sum_y    = 0;
    count    = 0;
    model_x  = '0;
    model_y  = '0;
    armed    = 1'b0;
    due      = 0;
  end

  ////////////////////////////////////////
  // reference rules

  // widened channels weighted, offset and clamped
  function automatic int cr_of(input rgb565_t p);
    int r, g, b, v;
    r = int'(p[15:11]) << 3;
    g = int'(p[10:5]) << 2;
    b = int'(p[4:0]) << 3;
    v = 128 + ((112 * r - 94 * g - 18 * b) >>> 8);
    v = (v < 0) ? 0 : v;
    return (v > 255) ? 255 : v;
  endfunction

  function automatic rgb444_t expect_pixel(input video_beat_t b, input logic m,
                                           input track_cfg_t c);
    rgb444_t cam;
    logic    line;
    cam  = {b.pixel[15:12], b.pixel[10:7], b.pixel[4:1]};
    line = (b.hcount < H_ACTIVE) && (b.vcount < V_ACTIVE)
           && ((b.hcount == model_x) || (b.vcount == model_y));
    if (b.blank) begin
      return '0;
    end
    case (c.view)
      VIEW_MASK:      return m ? 12'hFFF : 12'h000;
      VIEW_CROSSHAIR: return line ? 12'h0F0 : cam;
      default:        return cam;
    endcase
  endfunction

  ////////////////////////////////////////
  // reporting

  task automatic compare(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    test_checks++;
    total_checks++;
    if (expected !== actual) begin
      $display("Error: %s %s expected %0h actual %0h", test_name, what, expected, actual);
      test_errors++;
      total_errors++;
    end
  endtask

  task automatic fault(input string text);
    $display("test %s: %s", test_name, text);
    test_errors++;
    total_errors++;
  endtask

  task automatic open_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
    test_pulses = 0;
  endtask

  task automatic close_test(input logic need_pulse);
    if (need_pulse && test_pulses == 0) begin
      fault("no centroid update was seen");
    end
    $display("test %s finished: %0d checks, %0d errors, %0d centroid updates",
             test_name, test_checks, test_errors, test_pulses);
  endtask

  ////////////////////////////////////////
  // model and compare at the falling edge

  always @(negedge clk_65mhz) begin
    video_beat_t b;
    logic        m;
    int          nib;
    logic        pulse;
    beat_h[cyc % 8] = beat_in;
    // beat three cycles back is in the mask stage now
    b   = beat_h[(cyc + 5) % 8];
    nib = cr_of(b.pixel) >> 4;
    m   = !b.blank && (nib >= cfg.lower_bound) && (nib <= cfg.upper_bound);
    mask_h[(cyc + 5) % 8] = m;
    if (b.hcount == '0 && b.vcount == '0) begin
      // frame close shows its result 34 falling edges later
      if (count != 0) begin
        armed = 1'b1;
        due   = cyc + 34;
        exp_x = hcount_t'(sum_x / count);
        exp_y = vcount_t'(sum_y / count);
      end
      sum_x = m ? longint'(b.hcount) : 0;
      sum_y = m ? longint'(b.vcount) : 0;
      count = m ? 1 : 0;
    end else if (m) begin
      sum_x = sum_x + b.hcount;
      sum_y = sum_y + b.vcount;
      count = count + 1;
    end
    if (!sys_rst) begin
      // output belongs to the beat five cycles back
      b = beat_h[(cyc + 3) % 8];
      compare("pixel", expect_pixel(b, mask_h[(cyc + 3) % 8], cfg_prev), out_pixel);
      compare("syncs", {b.hsync, b.vsync}, {out_hsync, out_vsync});
      pulse = armed && (cyc == due);
      if (com_valid !== 1'b0 && !pulse) begin
        fault("com_valid pulsed with no frame to report");
      end
      if (com_valid !== 1'b1 && pulse) begin
        fault("com_valid did not pulse after a frame with masked pixels");
      end
      if (pulse) begin
        armed   = 1'b0;
        model_x = exp_x;
        model_y = exp_y;
        test_pulses += int'(com_valid);
      end
      compare("com_x", model_x, com_x);
      compare("com_y", model_y, com_y);
    end
    cfg_prev = cfg;
    cyc++;
  end

endmodule

`default_nettype wire

/* tests/tb_color_tracker.sv */
`default_nettype none

module tb_color_tracker import tracker_pkg::*; ();

  localparam int H_ACT      = 32;
  localparam int V_ACT      = 24;
  localparam int LINE_LEN   = 40;
  localparam int FRAME_ROWS = 28;
  // frames driven over all tests
  localparam int FRAMES         = 8;
  localparam int TIMEOUT_CYCLES = FRAMES * LINE_LEN * FRAME_ROWS + 200;
  localparam logic [31:0] LFSR_SEED = 32'h7344_08e1;

  logic        clk_65mhz;
  logic        sys_rst;
  video_beat_t beat_in;
  track_cfg_t  cfg;
  rgb444_t     out_pixel;
  logic        out_hsync, out_vsync;
  hcount_t     com_x;
  vcount_t     com_y;
  logic        com_valid;
  logic [31:0] lfsr;
  int          cycle_count;
  int          fail_total;

  color_tracker_top #(
    .H_ACTIVE (H_ACT),
    .V_ACTIVE (V_ACT)
  ) u_dut (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .beat_in   (beat_in),
    .cfg       (cfg),
    .out_pixel (out_pixel),
    .out_hsync (out_hsync),
    .out_vsync (out_vsync),
    .com_x     (com_x),
    .com_y     (com_y),
    .com_valid (com_valid)
  );

  tracker_checker #(
    .H_ACTIVE (H_ACT),
    .V_ACTIVE (V_ACT)
  ) u_check (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .beat_in   (beat_in),
    .cfg       (cfg),
    .out_pixel (out_pixel),
    .out_hsync (out_hsync),
    .out_vsync (out_vsync),
    .com_x     (com_x),
    .com_y     (com_y),
    .com_valid (com_valid)
  );

  initial clk_65mhz = 1'b0;
  always #4 clk_65mhz = ~clk_65mhz;

  ////////////////////////////////////////
  // random source

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    repeat (n) begin
      lfsr = galois_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  ////////////////////////////////////////
  // raster

  // blanked beat at 0,0
  task automatic drive_idle(input int n);
    repeat (n) begin
      @(posedge clk_65mhz);
      #1;
      beat_in = BEAT_IDLE;
    end
  endtask

  // 40x28 raster, one 8x6 red blob at a random place
  task automatic drive_frame();
    int          row, col;
    int          bx, by;
    video_beat_t b;
    bx = int'(rand_bits(4));
    by = int'(rand_bits(4));
    for (row = 0; row < FRAME_ROWS; row++) begin
      for (col = 0; col < LINE_LEN; col++) begin
        @(posedge clk_65mhz);
        #1;
        b.hcount = hcount_t'(col);
        b.vcount = vcount_t'(row);
        b.blank  = (col >= H_ACT) || (row >= V_ACT);
        b.hsync  = (col == 34) || (col == 35);
        b.vsync  = (row == 25) || (row == 26);
        if (col >= bx && col < bx + 8 && row >= by && row < by + 6) begin
          // strong red, little green and blue
          b.pixel = {5'd24 + 5'(rand_bits(3)), 6'(rand_bits(3)), 5'(rand_bits(3))};
        end else begin
          b.pixel = rgb565_t'(rand_bits(16));
        end
        beat_in = b;
      end
    end
  endtask

  task automatic set_random_bounds();
    nibble_t lo, hi, t;
    lo = nibble_t'(rand_bits(4));
    hi = nibble_t'(rand_bits(4));
    if (lo > hi) begin
      t  = lo;
      lo = hi;
      hi = t;
    end
    cfg = '{lower_bound: lo, upper_bound: hi, view: VIEW_MASK};
  endtask

  ////////////////////////////////////////
  // test sequence

  initial begin
    sys_rst = 1'b1;
    beat_in = BEAT_IDLE;
    cfg     = '{lower_bound: 4'd12, upper_bound: 4'd15, view: VIEW_CAMERA};
    lfsr    = LFSR_SEED;

    // outputs stay zero through reset and the idle beats after it
    u_check.open_test("reset_idle");
    repeat (4) @(posedge clk_65mhz);
    #1;
    sys_rst = 1'b0;
    drive_idle(8);
    u_check.close_test(1'b0);

    u_check.open_test("camera_view");
    drive_frame();
    u_check.close_test(1'b0);

    u_check.open_test("mask_view");
    repeat (2) begin
      set_random_bounds();
      drive_frame();
    end
    u_check.close_test(1'b0);

    // red band, blobs give a centroid each frame
    u_check.open_test("centroid");
    cfg = '{lower_bound: 4'd12, upper_bound: 4'd15, view: VIEW_MASK};
    repeat (2) drive_frame();
    u_check.close_test(1'b1);

    // empty band, held centroid drawn
    u_check.open_test("empty_frame");
    cfg = '{lower_bound: 4'd15, upper_bound: 4'd0, view: VIEW_CROSSHAIR};
    drive_frame();
    u_check.close_test(1'b0);

    u_check.open_test("crosshair");
    cfg = '{lower_bound: 4'd12, upper_bound: 4'd15, view: VIEW_CROSSHAIR};
    repeat (2) drive_frame();
    // closes the last frame and waits out its divide
    drive_idle(48);
    u_check.close_test(1'b1);

    fail_total = u_check.total_errors + u_dut.u_accum.u_props.fail_count;
    $display("all tests: %0d checks, %0d errors, %0d assertion failures",
             u_check.total_checks, u_check.total_errors,
             u_dut.u_accum.u_props.fail_count);
    if (fail_total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // run limit
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_65mhz);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* color_tracker.f */
verilog/tracker_pkg.sv
verilog/seq_divider.sv
verilog/chroma_convert.sv
verilog/chroma_mask.sv
verilog/centroid_accum.sv
verilog/crosshair_overlay.sv
verilog/color_tracker_top.sv
tests/tracker_props.sv
tests/tracker_checker.sv
tests/tb_color_tracker.sv

/* Bender.yml */
package:
  name: color_tracker

sources:
  - verilog/tracker_pkg.sv
  - verilog/seq_divider.sv
  - verilog/chroma_convert.sv
  - verilog/chroma_mask.sv
  - verilog/centroid_accum.sv
  - verilog/crosshair_overlay.sv
  - verilog/color_tracker_top.sv
  - target: test
    files:
      - tests/tracker_props.sv
      - tests/tracker_checker.sv
      - tests/tb_color_tracker.sv
